//--- dv/mem_merge_tb.sv
`timescale 1ns/1ps

module mem_merge_tb import mem_merge_pkg::*; ();

   localparam int CHANNEL_COUNT = 4;
   localparam int MEM_DEPTH     = 256;
   localparam int READ_LATENCY  = 2;
   localparam int CHAN_W        = $clog2(CHANNEL_COUNT);

   // one line of the stimulus file
   typedef struct packed {
      logic [7:0]  chan;
      logic [7:0]  kind;
      phrase_t     value;
      logic [31:0] count;
      logic        wen;
      logic [15:0] gap;
   } stim_line_t;

   logic              sys_clk;
   logic              sys_rst;
   logic              in_valid;
   logic [CHAN_W-1:0] in_chan;
   phrase_t           in_data;
   logic              in_tuser;
   logic              in_ready;
   logic              resp_valid;
   logic [CHAN_W-1:0] resp_chan;
   phrase_t           resp_data;

   stim_line_t stim_q[$];
   phrase_t    ref_mem [MEM_DEPTH];
   phrase_t    exp_data [CHANNEL_COUNT][$];
   int         exp_stream [CHANNEL_COUNT][$];
   int         wr_left [CHANNEL_COUNT];
   int         wr_addr [CHANNEL_COUNT];
   // read stream ids start at 1, zero means no stream seen yet
   int         stream_id [CHANNEL_COUNT];
   int         last_stream [CHANNEL_COUNT];
   // answers of channel b since channel a last answered
   int         since_last [CHANNEL_COUNT][CHANNEL_COUNT];
   int         err_count;
   int         resp_count;
   int         stall_cycles;
   int         watchdog_cycles;
   bit         loaded;

   mem_merge_top #(
      .CHANNEL_COUNT(CHANNEL_COUNT),
      .MEM_DEPTH    (MEM_DEPTH),
      .READ_LATENCY (READ_LATENCY)
   ) mem_merge_top_i (
      .sys_clk     (sys_clk),
      .sys_rst     (sys_rst),
      .in_valid_i  (in_valid),
      .in_chan_i   (in_chan),
      .in_data_i   (in_data),
      .in_tuser_i  (in_tuser),
      .in_ready_o  (in_ready),
      .resp_valid_o(resp_valid),
      .resp_chan_o (resp_chan),
      .resp_data_o (resp_data)
   );

   initial begin
      sys_clk = 1'b0;
      forever begin
         #5 sys_clk = ~sys_clk;
      end
   end

   initial begin
      wait (loaded);
      repeat (watchdog_cycles) @(posedge sys_clk);
      $display("timeout after %0d cycles, read responses are still missing", watchdog_cycles);
      $display("Simulation failed");
      $finish;
   end

   task automatic load_stimulus();
      int         fd;
      int         chan;
      int         count;
      int         wen;
      int         gap;
      logic [7:0] kind;
      phrase_t    value;
      string      line;
      stim_line_t entry;
      fd = $fopen("dv/stimulus_input.txt", "r");
      if (fd == 0) begin
         $display("cannot open dv/stimulus_input.txt, there is nothing to run");
         err_count++;
         return;
      end
      // comment lines do not match the six columns and are skipped
      while ($fgets(line, fd) != 0) begin
         if ($sscanf(line, "%d %s %h %d %d %d", chan, kind, value, count, wen, gap) == 6) begin
            entry.chan  = 8'(chan);
            entry.kind  = kind;
            entry.value = value;
            entry.count = 32'(count);
            entry.wen   = wen[0];
            entry.gap   = 16'(gap);
            stim_q.push_back(entry);
         end
      end
      $fclose(fd);
   endtask

   // hold the phrase until the addressed lane takes it
   task automatic send_phrase(input int chan, input phrase_t data, input logic tuser);
      logic accepted;
      in_valid = 1'b1;
      in_chan  = CHAN_W'(chan);
      in_data  = data;
      in_tuser = tuser;
      accepted = 1'b0;
      while (!accepted) begin
         @(negedge sys_clk);
         accepted = in_ready;
         if (!accepted) begin
            stall_cycles++;
         end
         @(posedge sys_clk);
         #1;
      end
      in_valid = 1'b0;
   endtask

   // a phrase outside a write stream never reaches memory
   task automatic model_data(input int chan, input phrase_t data);
      if (wr_left[chan] > 0) begin
         ref_mem[wr_addr[chan] % MEM_DEPTH] = data;
         wr_addr[chan]++;
         wr_left[chan]--;
      end
   endtask

   task automatic run_line(input stim_line_t s);
      int              chan;
      int              gap;
      phrase_t         data;
      channel_update_t cmd;
      chan = int'(s.chan);
      if (s.kind == "C") begin
         cmd.addr          = ADDR_W'(s.value);
         cmd.stream_length = LEN_W'(s.count);
         cmd.wen           = s.wen;
         data = '0;
         data[$bits(channel_update_t)-1:0] = cmd;
         send_phrase(chan, data, 1'b1);
         if (wr_left[chan] > 0) begin
            // an open write stream takes even a tuser phrase as data
            model_data(chan, data);
         end else if (cmd.wen) begin
            wr_left[chan] = int'(cmd.stream_length);
            wr_addr[chan] = int'(cmd.addr);
         end else if (cmd.stream_length != '0) begin
            stream_id[chan]++;
            for (int i = 0; i < int'(cmd.stream_length); i++) begin
               exp_data[chan].push_back(ref_mem[(int'(cmd.addr) + i) % MEM_DEPTH]);
               exp_stream[chan].push_back(stream_id[chan]);
            end
         end
      end else begin
         for (int i = 0; i < int'(s.count); i++) begin
            data = s.value + phrase_t'(i);
            send_phrase(chan, data, 1'b0);
            model_data(chan, data);
         end
      end
      // random extra idle cycles only where the file asks for a gap
      gap = int'(s.gap);
      if (gap > 0) begin
         gap += int'($urandom % 3);
      end
      repeat (gap) begin
         @(posedge sys_clk);
         #1;
      end
   endtask

   function automatic int outstanding();
      int total;
      total = 0;
      for (int c = 0; c < CHANNEL_COUNT; c++) begin
         total += exp_data[c].size();
      end
      return total;
   endfunction

   always @(negedge sys_clk) begin
      int      chan;
      int      sid;
      phrase_t expected;
      if (!sys_rst && resp_valid) begin
         chan = int'(resp_chan);
         resp_count++;
         if (exp_data[chan].size() == 0) begin
            $display("time %0t: response on channel %0d with no read outstanding", $time, chan);
            err_count++;
         end else begin
            expected = exp_data[chan].pop_front();
            sid      = exp_stream[chan].pop_front();
            if (resp_data !== expected) begin
               $display("[ERROR] %0t resp_data_o channel %0d expected %h actual %h",
                        $time, chan, expected, resp_data);
               err_count++;
            end
            // inside one read stream every other channel answers at most once in between
            for (int o = 0; o < CHANNEL_COUNT; o++) begin
               if (o != chan && sid == last_stream[chan] && since_last[chan][o] > 1) begin
                  $display("[ERROR] %0t resp_chan_o answers of %0d inside stream of %0d %s %0d",
                           $time, o, chan, "expected at most 1 actual", since_last[chan][o]);
                  err_count++;
               end
               since_last[chan][o] = 0;
               since_last[o][chan]++;
            end
            last_stream[chan] = sid;
         end
      end
   end

   initial begin
      int drain_limit;
      int drain_cycles;
      sys_rst  = 1'b1;
      in_valid = 1'b0;
      in_chan  = '0;
      in_data  = '0;
      in_tuser = 1'b0;
      void'($urandom(32'h7d7f_6e2d));
      load_stimulus();
      watchdog_cycles = 20 * stim_q.size() * READ_LATENCY + 1000;
      loaded = 1'b1;

      repeat (4) @(posedge sys_clk);
      #1;
      sys_rst = 1'b0;
      // every lane idle, so every channel is ready
      for (int c = 0; c < CHANNEL_COUNT; c++) begin
         in_chan = CHAN_W'(c);
         @(negedge sys_clk);
         if (in_ready !== 1'b1 || resp_valid !== 1'b0) begin
            $display("[ERROR] %0t in_ready_o/resp_valid_o channel %0d expected 1/0 actual %b/%b",
                     $time, c, in_ready, resp_valid);
            err_count++;
         end
         @(posedge sys_clk);
         #1;
      end

      foreach (stim_q[k]) begin
         run_line(stim_q[k]);
      end
      // each owed response needs at most one full arbitration round
      drain_limit  = (outstanding() + READ_LATENCY) * CHANNEL_COUNT + 100;
      drain_cycles = 0;
      while (outstanding() != 0 && drain_cycles < drain_limit) begin
         @(posedge sys_clk);
         drain_cycles++;
      end
      // give stray extra responses time to show up
      repeat (READ_LATENCY + 4) @(posedge sys_clk);

      for (int c = 0; c < CHANNEL_COUNT; c++) begin
         if (exp_data[c].size() != 0) begin
            $display("channel %0d still waits for %0d read responses", c, exp_data[c].size());
            err_count++;
         end
      end
      if (stall_cycles == 0) begin
         $display("no phrase was ever held back by a busy lane");
         err_count++;
      end
      $display("errors: %0d, responses: %0d, stall cycles: %0d",
               err_count, resp_count, stall_cycles);
      if (err_count == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- dv/stimulus_input.txt
# chan kind value count wen gap
# C: value = start address, count = stream length | D: value = first phrase, count = phrases
0 C 010 4 1 0
0 D 0a0a0a0a00000000111122223333ff00 4 0 0
0 C 010 4 0 2
1 C 040 6 1 0
2 C 080 5 1 0
1 D 1b1b1b1b44445555666677778888aa10 3 0 0
3 C 0c0 3 1 0
2 D 2c2c2c2c9999aaaabbbbccccdddd5520 5 0 1
0 C 018 2 1 0
1 D 1b1b1b1b44445555666677778888bb30 3 0 0
3 D 3d3d3d3deeeeffff0000111122226640 3 0 0
0 D 0a0a0a0a00000000111122223333ee50 2 0 3
1 C 040 6 0 0
2 C 080 5 0 0
3 C 0c0 3 0 0
0 C 018 2 0 0
0 C 010 4 0 4
1 C 040 6 0 0
2 C 080 5 0 6
2 D 5a5a5a5adeadbeefdeadbeefdeadbeef 1 0 2
2 C 080 5 0 0
3 C 0c0 0 0 1
3 C 0fc 8 1 0
3 D 3d3d3d3d777788889999aaaabbbb7700 8 0 0
3 C 0fc 8 0 0
3 C 100 4 0 3

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module mem_merge_tb -o mem_merge_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/mem_merge_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "Simulation passed"; then
   exit 0
fi
exit 1

//--- source/channel_lane.sv
`timescale 1ns/1ps

module channel_lane import mem_merge_pkg::*; (
   input  logic     sys_clk,
   input  logic     sys_rst,
   input  logic     ph_valid_i,
   input  phrase_t  ph_data_i,
   input  logic     ph_tuser_i,
   output logic     ph_ready_o,
   output logic     req_valid_o,
   output mem_req_t req_o,
   input  logic     grant_i
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WRITE,
      ST_READ
   } lane_state_t;

   lane_state_t       state_q;
   logic [ADDR_W-1:0] cur_addr_q;
   logic [LEN_W-1:0]  remaining_q;
   logic              req_valid_q;
   mem_req_t          req_q;

   channel_update_t   cmd;
   logic              accept;
   logic              cmd_take;
   logic              last_req;

   assign cmd      = ph_data_i[$bits(channel_update_t)-1:0];
   assign accept   = ph_valid_i && ph_ready_o;
   // zero-length commands are swallowed in idle
   assign cmd_take = (state_q == ST_IDLE) && accept && ph_tuser_i
                     && (cmd.stream_length != '0);
   assign last_req = (remaining_q == LEN_W'(1));

   // idle takes anything, write waits for an empty slot, read takes nothing
   always_comb begin
      case (state_q)
         ST_IDLE:  ph_ready_o = 1'b1;
         ST_WRITE: ph_ready_o = !req_valid_q;
         default:  ph_ready_o = 1'b0;
      endcase
   end

   always_ff @(posedge sys_clk) begin
      if (sys_rst) begin
         state_q     <= ST_IDLE;
         req_valid_q <= 1'b0;
         cur_addr_q  <= '0;
         remaining_q <= '0;
      end else begin
         if (cmd_take) begin
            cur_addr_q  <= cmd.addr;
            remaining_q <= cmd.stream_length;
         end else if (grant_i) begin
            cur_addr_q  <= cur_addr_q + ADDR_W'(1);
            remaining_q <= remaining_q - LEN_W'(1);
         end

         case (state_q)
            ST_IDLE: begin
               if (cmd_take && cmd.wen) begin
                  state_q <= ST_WRITE;
               end else if (cmd_take) begin
                  // first read request shows up on the next cycle
                  state_q     <= ST_READ;
                  req_valid_q <= 1'b1;
               end
            end
            ST_WRITE: begin
               // tuser is ignored here, every phrase is data
               if (accept) begin
                  req_valid_q <= 1'b1;
               end else if (grant_i) begin
                  req_valid_q <= 1'b0;
                  if (last_req) begin
                     state_q <= ST_IDLE;
                  end
               end
            end
            default: begin
               if (grant_i && last_req) begin
                  req_valid_q <= 1'b0;
                  state_q     <= ST_IDLE;
               end
            end
         endcase
      end
   end

   // request slot
   always_ff @(posedge sys_clk) begin
      if (cmd_take && !cmd.wen) begin
         req_q.addr <= cmd.addr;
         req_q.wen  <= 1'b0;
      end else if (state_q == ST_WRITE && accept) begin
         req_q.addr <= cur_addr_q;
         req_q.wen  <= 1'b1;
         req_q.data <= ph_data_i;
      end else if (state_q == ST_READ && grant_i) begin
         // next read address, valid stays up
         req_q.addr <= cur_addr_q + ADDR_W'(1);
      end
   end

   assign req_valid_o = req_valid_q;
   assign req_o       = req_q;

   // the arbiter may only grant a pending request
   grant_has_req_a : assert property (
      @(posedge sys_clk) disable iff (sys_rst)
      grant_i |-> req_valid_o
   );

endmodule

//--- source/mem_merge_pkg.sv
package mem_merge_pkg;

   // phrase is the unit of every transfer and of memory storage
   localparam int PHRASE_W = 128;

   // command field widths, matching the channel-update layout
   localparam int ADDR_W = 27;
   localparam int LEN_W  = 27;

   typedef logic [PHRASE_W-1:0] phrase_t;

   // channel-update command
   // sits in the low 55 bits of a phrase marked by tuser
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [LEN_W-1:0]  stream_length;
      logic              wen;
   } channel_update_t;

   // one memory request as issued by a lane
   // data is only meaningful when wen is set
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic              wen;
      phrase_t           data;
   } mem_req_t;

endpackage

//--- source/mem_merge_top.sv
`timescale 1ns/1ps

module mem_merge_top import mem_merge_pkg::*; #(
   parameter int CHANNEL_COUNT = 4,
   parameter int MEM_DEPTH     = 256,
   parameter int READ_LATENCY  = 2,
   localparam int CHAN_W = (CHANNEL_COUNT > 1) ? $clog2(CHANNEL_COUNT) : 1
) (
   input  logic              sys_clk,
   input  logic              sys_rst,
   input  logic              in_valid_i,
   input  logic [CHAN_W-1:0] in_chan_i,
   input  phrase_t           in_data_i,
   input  logic              in_tuser_i,
   output logic              in_ready_o,
   output logic              resp_valid_o,
   output logic [CHAN_W-1:0] resp_chan_o,
   output phrase_t           resp_data_o
);

   // router to lanes
   logic     [CHANNEL_COUNT-1:0] lane_valid;
   phrase_t                      lane_data;
   logic                         lane_tuser;
   logic     [CHANNEL_COUNT-1:0] lane_ready;

   // lanes to arbiter
   logic     [CHANNEL_COUNT-1:0] req_valid;
   mem_req_t [CHANNEL_COUNT-1:0] lane_req;
   logic     [CHANNEL_COUNT-1:0] grant;

   // arbiter to memory and back
   logic                         mem_strobe;
   mem_req_t                     mem_req;
   logic                         rd_valid;
   phrase_t                      rd_data;

   stream_router #(
      .CHANNEL_COUNT(CHANNEL_COUNT)
   ) stream_router_i (
      .sys_clk     (sys_clk),
      .sys_rst     (sys_rst),
      .in_valid_i  (in_valid_i),
      .in_chan_i   (in_chan_i),
      .in_data_i   (in_data_i),
      .in_tuser_i  (in_tuser_i),
      .in_ready_o  (in_ready_o),
      .lane_valid_o(lane_valid),
      .lane_data_o (lane_data),
      .lane_tuser_o(lane_tuser),
      .lane_ready_i(lane_ready)
   );

   // one identical lane per channel
   for (genvar g = 0; g < CHANNEL_COUNT; g++) begin : g_lane
      channel_lane channel_lane_i (
         .sys_clk    (sys_clk),
         .sys_rst    (sys_rst),
         .ph_valid_i (lane_valid[g]),
         .ph_data_i  (lane_data),
         .ph_tuser_i (lane_tuser),
         .ph_ready_o (lane_ready[g]),
         .req_valid_o(req_valid[g]),
         .req_o      (lane_req[g]),
         .grant_i    (grant[g])
      );
   end

   round_robin_arbiter #(
      .CHANNEL_COUNT(CHANNEL_COUNT),
      .READ_LATENCY (READ_LATENCY)
   ) round_robin_arbiter_i (
      .sys_clk     (sys_clk),
      .sys_rst     (sys_rst),
      .req_valid_i (req_valid),
      .req_i       (lane_req),
      .grant_o     (grant),
      .mem_strobe_o(mem_strobe),
      .mem_req_o   (mem_req),
      .rd_valid_i  (rd_valid),
      .rd_data_i   (rd_data),
      .resp_valid_o(resp_valid_o),
      .resp_chan_o (resp_chan_o),
      .resp_data_o (resp_data_o)
   );

   phrase_memory #(
      .MEM_DEPTH   (MEM_DEPTH),
      .READ_LATENCY(READ_LATENCY)
   ) phrase_memory_i (
      .sys_clk   (sys_clk),
      .sys_rst   (sys_rst),
      .strobe_i  (mem_strobe),
      .req_i     (mem_req),
      .rd_valid_o(rd_valid),
      .rd_data_o (rd_data)
   );

endmodule

//--- source/phrase_memory.sv
`timescale 1ns/1ps

module phrase_memory import mem_merge_pkg::*; #(
   parameter int MEM_DEPTH    = 256,
   parameter int READ_LATENCY = 2,
   localparam int IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1
) (
   input  logic     sys_clk,
   input  logic     sys_rst,
   input  logic     strobe_i,
   input  mem_req_t req_i,
   output logic     rd_valid_o,
   output phrase_t  rd_data_o
);

   phrase_t                 mem_q [MEM_DEPTH];
   phrase_t                 rd_data_q [READ_LATENCY];
   logic [READ_LATENCY-1:0] rd_valid_q;
   logic [IDX_W-1:0]        mem_idx;

   // address wraps modulo depth
   assign mem_idx = IDX_W'(req_i.addr % ADDR_W'(MEM_DEPTH));

   // write lands on the strobe edge, read is captured into stage 0
   always_ff @(posedge sys_clk) begin
      if (strobe_i && req_i.wen) begin
         mem_q[mem_idx] <= req_i.data;
      end
      if (strobe_i && !req_i.wen) begin
         rd_data_q[0] <= mem_q[mem_idx];
      end
      for (int i = 1; i < READ_LATENCY; i++) begin
         rd_data_q[i] <= rd_data_q[i-1];
      end
   end

   always_ff @(posedge sys_clk) begin
      if (sys_rst) begin
         rd_valid_q <= '0;
      end else begin
         rd_valid_q[0] <= strobe_i && !req_i.wen;
         for (int i = 1; i < READ_LATENCY; i++) begin
            rd_valid_q[i] <= rd_valid_q[i-1];
         end
      end
   end

   assign rd_valid_o = rd_valid_q[READ_LATENCY-1];
   assign rd_data_o  = rd_data_q[READ_LATENCY-1];

endmodule

//--- source/round_robin_arbiter.sv
`timescale 1ns/1ps

module round_robin_arbiter import mem_merge_pkg::*; #(
   parameter int CHANNEL_COUNT = 4,
   parameter int READ_LATENCY  = 2,
   localparam int CHAN_W = (CHANNEL_COUNT > 1) ? $clog2(CHANNEL_COUNT) : 1
) (
   input  logic                               sys_clk,
   input  logic                               sys_rst,
   input  logic     [CHANNEL_COUNT-1:0]       req_valid_i,
   input  mem_req_t [CHANNEL_COUNT-1:0]       req_i,
   output logic     [CHANNEL_COUNT-1:0]       grant_o,
   output logic                               mem_strobe_o,
   output mem_req_t                           mem_req_o,
   input  logic                               rd_valid_i,
   input  phrase_t                            rd_data_i,
   output logic                               resp_valid_o,
   output logic     [CHAN_W-1:0]              resp_chan_o,
   output phrase_t                            resp_data_o
);

   logic [CHAN_W-1:0]       last_q;
   logic [CHAN_W-1:0]       grant_idx;
   logic                    found;
   logic [READ_LATENCY-1:0] rd_pend_q;
   logic [CHAN_W-1:0]       rd_chan_q [READ_LATENCY];

   // search starts one past the last winner and wraps around
   always_comb begin
      int idx;
      grant_o   = '0;
      grant_idx = last_q;
      found     = 1'b0;
      for (int off = 1; off <= CHANNEL_COUNT; off++) begin
         idx = (int'(last_q) + off) % CHANNEL_COUNT;
         if (!found && req_valid_i[idx]) begin
            found     = 1'b1;
            grant_idx = CHAN_W'(idx);
         end
      end
      if (found) begin
         grant_o[grant_idx] = 1'b1;
      end
   end

   assign mem_strobe_o = found;
   assign mem_req_o    = req_i[grant_idx];

   // lane 0 wins first after reset
   always_ff @(posedge sys_clk) begin
      if (sys_rst) begin
         last_q    <= CHAN_W'(CHANNEL_COUNT - 1);
         rd_pend_q <= '0;
      end else begin
         if (found) begin
            last_q <= grant_idx;
         end
         rd_pend_q[0] <= found && !mem_req_o.wen;
         for (int i = 1; i < READ_LATENCY; i++) begin
            rd_pend_q[i] <= rd_pend_q[i-1];
         end
      end
   end

   // channel id travels beside each read through the memory latency
   always_ff @(posedge sys_clk) begin
      rd_chan_q[0] <= grant_idx;
      for (int i = 1; i < READ_LATENCY; i++) begin
         rd_chan_q[i] <= rd_chan_q[i-1];
      end
   end

   // responses are tagged and passed on, no stall possible
   assign resp_valid_o = rd_valid_i;
   assign resp_chan_o  = rd_chan_q[READ_LATENCY-1];
   assign resp_data_o  = rd_data_i;

   onehot_grant_a : assert property (
      @(posedge sys_clk) disable iff (sys_rst)
      $onehot0(grant_o)
   );

   // memory must return data exactly when a tracked read comes due
   rd_return_a : assert property (
      @(posedge sys_clk) disable iff (sys_rst)
      rd_valid_i == rd_pend_q[READ_LATENCY-1]
   );

endmodule

//--- source/stream_router.sv
`timescale 1ns/1ps

module stream_router import mem_merge_pkg::*; #(
   parameter int CHANNEL_COUNT = 4,
   localparam int CHAN_W = (CHANNEL_COUNT > 1) ? $clog2(CHANNEL_COUNT) : 1
) (
   input  logic                     sys_clk,
   input  logic                     sys_rst,
   input  logic                     in_valid_i,
   input  logic [CHAN_W-1:0]        in_chan_i,
   input  phrase_t                  in_data_i,
   input  logic                     in_tuser_i,
   output logic                     in_ready_o,
   output logic [CHANNEL_COUNT-1:0] lane_valid_o,
   output phrase_t                  lane_data_o,
   output logic                     lane_tuser_o,
   input  logic [CHANNEL_COUNT-1:0] lane_ready_i
);

   logic chan_ok;

   // channel ids past the lane count address nothing
   assign chan_ok = ({1'b0, in_chan_i} < (CHAN_W + 1)'(CHANNEL_COUNT));

   // one-hot valid towards the addressed lane
   always_comb begin
      lane_valid_o = '0;
      if (in_valid_i && chan_ok) begin
         lane_valid_o[in_chan_i] = 1'b1;
      end
   end

   // payload goes to every lane, only the valid lane takes it
   assign lane_data_o  = in_data_i;
   assign lane_tuser_o = in_tuser_i;

   // ready comes straight back from the addressed lane, no added cycle
   always_comb begin
      in_ready_o = 1'b0;
      if (chan_ok) begin
         in_ready_o = lane_ready_i[in_chan_i];
      end
   end

   // the sender must only address lanes that exist
   chan_in_range_a : assert property (
      @(posedge sys_clk) disable iff (sys_rst)
      in_valid_i |-> chan_ok
   );

endmodule

//--- sources.f
source/mem_merge_pkg.sv
source/stream_router.sv
source/channel_lane.sv
source/round_robin_arbiter.sv
source/phrase_memory.sv
source/mem_merge_top.sv
dv/mem_merge_tb.sv
